//--- source/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// width of rs, rt, results and hi/lo
`define EXEC_DATA_W 32

// raw immediate field from the instruction word
`define EXEC_IMM_W 16

// one iteration per bit of the operand
`define EXEC_MULDIV_CYCLES 32

`endif

//--- source/exec_pkg.sv
package exec_pkg;

    // decoded opcodes handed over by the requester
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        // signed compare
        OP_SLT   = 4'd5,
        OP_SLTU  = 4'd6,
        // rt shifted by immed[4:0]
        OP_SLL   = 4'd7,
        OP_ADDI  = 4'd8,
        // multi-cycle, write hi/lo
        OP_MULTU = 4'd9,
        OP_DIVU  = 4'd10,
        OP_MFHI  = 4'd11,
        OP_MFLO  = 4'd12
    } exec_op_t;

    // handshake and sequencing states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_EXEC   = 2'd1,
        ST_MULDIV = 2'd2,
        ST_DONE   = 2'd3
    } exec_state_t;

endpackage

//--- source/exec_op_if.sv
`include "exec_settings.svh"

interface exec_op_if import exec_pkg::*; ();

    // instruction bundle as latched on capture
    exec_op_t                 op;
    logic [`EXEC_DATA_W-1:0]  a;
    logic [`EXEC_DATA_W-1:0]  b;
    logic [`EXEC_IMM_W-1:0]   immed;
    logic [`EXEC_DATA_W-1:0]  pcadd4;

    modport src (
        output op,
        output a,
        output b,
        output immed,
        output pcadd4
    );

    // the fsm only looks at the opcode
    modport ctl (
        input op
    );

    // multiply/divide consumer
    modport usr (
        input op,
        input a,
        input b
    );

endinterface

//--- source/exec_control_fsm.sv
`include "exec_settings.svh"

module exec_control_fsm import exec_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          req,
    exec_op_if.ctl        ops,
    input  logic          last,
    output logic          capture,
    output logic          commit,
    output logic          start,
    output logic          ack
);

    exec_state_t state;
    exec_state_t state_nxt;
    logic        need_muldiv;

    // multiply and divide take the long path through the counter
    assign need_muldiv = (ops.op == OP_MULTU) || (ops.op == OP_DIVU);

    always_comb begin
        state_nxt = state;
        capture   = 1'b0;
        commit    = 1'b0;
        start     = 1'b0;

        case (state)
            ST_IDLE: begin
                if (req) begin
                    capture   = 1'b1;
                    state_nxt = ST_EXEC;
                end
            end

            ST_EXEC: begin
                commit = 1'b1;
                if (need_muldiv) begin
                    start     = 1'b1;
                    state_nxt = ST_MULDIV;
                end else begin
                    state_nxt = ST_DONE;
                end
            end

            ST_MULDIV: begin
                // hi/lo are written on the same edge
                if (last) begin
                    state_nxt = ST_DONE;
                end
            end

            ST_DONE: begin
                // hold ack and outputs until the requester lets go
                if (!req) begin
                    state_nxt = ST_IDLE;
                end
            end

            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_nxt;
            // registered so ack tracks ST_DONE exactly
            ack   <= (state_nxt == ST_DONE);
        end
    end

endmodule

//--- source/muldiv_cycle_counter.sv
`include "exec_settings.svh"

module muldiv_cycle_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic busy,
    output logic last
);

    localparam int CNT_W = $clog2(`EXEC_MULDIV_CYCLES);

    logic [CNT_W-1:0] count;

    // final iteration
    assign last = busy && (count == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= CNT_W'(`EXEC_MULDIV_CYCLES - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/muldiv_unit.sv
`include "exec_settings.svh"

module muldiv_unit import exec_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    exec_op_if.usr                  ops,
    input  logic                    start,
    input  logic                    busy,
    input  logic                    last,
    output logic [`EXEC_DATA_W-1:0] hi,
    output logic [`EXEC_DATA_W-1:0] lo
);

    localparam int W = `EXEC_DATA_W;

    // mul: {partial product, remaining multiplier}
    // div: {partial remainder, dividend shifting into quotient}
    logic [2*W-1:0] work;
    logic [2*W-1:0] work_nxt;
    // multiplicand or divisor
    logic [W-1:0]   oper;
    logic           is_div;

    logic [W:0]     mul_sum;
    logic [W:0]     rem_shift;
    logic [W:0]     rem_diff;
    logic           rem_ge;

    // one shift-add step
    assign mul_sum = {1'b0, work[2*W-1:W]} + (work[0] ? {1'b0, oper} : '0);

    // one restoring step, the divisor is subtracted only if it fits
    assign rem_shift = {work[2*W-1:W], work[W-1]};
    assign rem_diff  = rem_shift - {1'b0, oper};
    assign rem_ge    = rem_shift >= {1'b0, oper};

    always_comb begin
        if (is_div) begin
            work_nxt = {rem_ge ? rem_diff[W-1:0] : rem_shift[W-1:0],
                        work[W-2:0], rem_ge};
        end else begin
            work_nxt = {mul_sum, work[W-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div <= (ops.op == OP_DIVU);
            if (ops.op == OP_DIVU) begin
                work <= {{W{1'b0}}, ops.a};
                oper <= ops.b;
            end else begin
                work <= {{W{1'b0}}, ops.b};
                oper <= ops.a;
            end
        end else if (busy) begin
            work <= work_nxt;
        end
    end

    // hi/lo only move when the whole operation is done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (last) begin
            hi <= work_nxt[2*W-1:W];
            lo <= work_nxt[W-1:0];
        end
    end

endmodule

//--- source/alu_datapath.sv
`include "exec_settings.svh"

module alu_datapath import exec_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  exec_op_t                op,
    input  logic [`EXEC_DATA_W-1:0] rs,
    input  logic [`EXEC_DATA_W-1:0] rt,
    input  logic [`EXEC_IMM_W-1:0]  immed,
    input  logic [`EXEC_DATA_W-1:0] pcadd4,
    exec_op_if.src                  ops,
    input  logic                    capture,
    input  logic                    commit,
    input  logic [`EXEC_DATA_W-1:0] hi,
    input  logic [`EXEC_DATA_W-1:0] lo,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic [`EXEC_DATA_W-1:0] pc_branch,
    output logic [`EXEC_DATA_W-1:0] mem_addr,
    output logic                    flag
);

    localparam int W  = `EXEC_DATA_W;
    localparam int SH = $clog2(W);

    logic [W-1:0] sign_immed;
    logic [W-1:0] alu_out;

    // operands stay put for the whole transaction
    always_ff @(posedge clk) begin
        if (capture) begin
            ops.op     <= op;
            ops.a      <= rs;
            ops.b      <= rt;
            ops.immed  <= immed;
            ops.pcadd4 <= pcadd4;
        end
    end

    assign sign_immed = {{(W - `EXEC_IMM_W){ops.immed[`EXEC_IMM_W-1]}}, ops.immed};

    always_comb begin
        case (ops.op)
            OP_ADD:  alu_out = ops.a + ops.b;
            OP_SUB:  alu_out = ops.a - ops.b;
            OP_AND:  alu_out = ops.a & ops.b;
            OP_OR:   alu_out = ops.a | ops.b;
            OP_XOR:  alu_out = ops.a ^ ops.b;
            OP_SLT:  alu_out = W'($signed(ops.a) < $signed(ops.b));
            OP_SLTU: alu_out = W'(ops.a < ops.b);
            OP_SLL:  alu_out = ops.b << ops.immed[SH-1:0];
            OP_ADDI: alu_out = ops.a + sign_immed;
            OP_MFHI: alu_out = hi;
            OP_MFLO: alu_out = lo;
            // multu/divu report through hi/lo only
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result    <= '0;
            flag      <= 1'b0;
            pc_branch <= '0;
            mem_addr  <= '0;
        end else if (commit) begin
            result    <= alu_out;
            flag      <= (ops.a == ops.b);
            // word offset
            pc_branch <= ops.pcadd4 + (sign_immed << 2);
            mem_addr  <= ops.a + sign_immed;
        end
    end

endmodule

//--- source/exec_unit_top.sv
`include "exec_settings.svh"

module exec_unit_top import exec_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  exec_op_t                op,
    input  logic [`EXEC_DATA_W-1:0] rs,
    input  logic [`EXEC_DATA_W-1:0] rt,
    input  logic [`EXEC_IMM_W-1:0]  immed,
    input  logic [`EXEC_DATA_W-1:0] pcadd4,
    output logic                    ack,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    flag,
    output logic [`EXEC_DATA_W-1:0] pc_branch,
    output logic [`EXEC_DATA_W-1:0] mem_addr,
    output logic [`EXEC_DATA_W-1:0] hi,
    output logic [`EXEC_DATA_W-1:0] lo
);

    logic capture;
    logic commit;
    logic start;
    logic busy;
    logic last;

    // latched instruction bundle
    exec_op_if u_ops ();

    exec_control_fsm u_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ops     (u_ops),
        .last    (last),
        .capture (capture),
        .commit  (commit),
        .start   (start),
        .ack     (ack)
    );

    muldiv_cycle_counter u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .last  (last)
    );

    muldiv_unit u_mdu (
        .clk   (clk),
        .rst_n (rst_n),
        .ops   (u_ops),
        .start (start),
        .busy  (busy),
        .last  (last),
        .hi    (hi),
        .lo    (lo)
    );

    alu_datapath u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .rs        (rs),
        .rt        (rt),
        .immed     (immed),
        .pcadd4    (pcadd4),
        .ops       (u_ops),
        .capture   (capture),
        .commit    (commit),
        .hi        (hi),
        .lo        (lo),
        .result    (result),
        .pc_branch (pc_branch),
        .mem_addr  (mem_addr),
        .flag      (flag)
    );

endmodule

//--- verif/exec_unit_sva.sv
`include "exec_settings.svh"

module exec_unit_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    req,
    input logic                    ack,
    input logic [`EXEC_DATA_W-1:0] result,
    input logic [`EXEC_DATA_W-1:0] hi
);

    ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
        else $error("ack high in the cycle after reset");

    // ack only answers a pending request
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    ack_held_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else $error("ack dropped while req still high");

    ack_drops_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && !req) |=> !ack)
        else $error("ack not dropped one cycle after req went low");

    // outputs frozen for the whole ack phase
    outputs_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> ($stable(result) && $stable(hi)))
        else $error("result or hi changed while ack high");

endmodule

bind exec_unit_top exec_unit_sva u_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .ack    (ack),
    .result (result),
    .hi     (hi)
);

//--- verif/exec_unit_tb.sv
`include "exec_settings.svh"

module exec_unit_tb import exec_pkg::*; ();

    localparam int W          = `EXEC_DATA_W;
    localparam int N_RANDOM   = 300;
    localparam int WAIT_LIMIT = 100;

    logic                   clk;
    logic                   rst_n;
    logic                   req;
    exec_op_t               op;
    logic [W-1:0]           rs;
    logic [W-1:0]           rt;
    logic [`EXEC_IMM_W-1:0] immed;
    logic [W-1:0]           pcadd4;
    logic                   ack;
    logic                   flag;
    logic [W-1:0]           result;
    logic [W-1:0]           pc_branch;
    logic [W-1:0]           mem_addr;
    logic [W-1:0]           hi;
    logic [W-1:0]           lo;

    // reference model state and expected outputs
    logic [W-1:0] hi_m;
    logic [W-1:0] lo_m;
    logic [W-1:0] exp_result;
    logic [W-1:0] exp_pc_branch;
    logic [W-1:0] exp_mem_addr;
    logic         exp_flag;

    int value_errors;
    int timeout_errors;
    bit timed_out;

    exec_unit_top uut (.*);

    always #4 clk = ~clk;

    function automatic logic [W-1:0] sign_extend(input logic [`EXEC_IMM_W-1:0] imm);
        return {{(W - `EXEC_IMM_W){imm[`EXEC_IMM_W-1]}}, imm};
    endfunction

    // corner values mixed into the random operands
    function automatic logic [W-1:0] pick_operand();
        case ($urandom_range(7))
            0: return '0;
            1: return '1;
            2: return {1'b1, {(W-1){1'b0}}};
            default: return $urandom;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic model_expect(input exec_op_t o, input logic [W-1:0] a,
                                input logic [W-1:0] b, input logic [`EXEC_IMM_W-1:0] imm,
                                input logic [W-1:0] pc);
        logic [W-1:0]   sx;
        logic [2*W-1:0] prod;
        sx   = sign_extend(imm);
        prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        case (o)
            OP_ADD:  exp_result = a + b;
            OP_SUB:  exp_result = a - b;
            OP_AND:  exp_result = a & b;
            OP_OR:   exp_result = a | b;
            OP_XOR:  exp_result = a ^ b;
            OP_SLT:  exp_result = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU: exp_result = {{(W-1){1'b0}}, a < b};
            OP_SLL:  exp_result = b << imm[4:0];
            OP_ADDI: exp_result = a + sx;
            OP_MFHI: exp_result = hi_m;
            OP_MFLO: exp_result = lo_m;
            default: exp_result = '0;
        endcase
        if (o == OP_MULTU) begin
            {hi_m, lo_m} = prod;
        end else if (o == OP_DIVU) begin
            // divide by zero falls out of the restoring steps
            if (b == '0) begin
                hi_m = a;
                lo_m = '1;
            end else begin
                hi_m = a % b;
                lo_m = a / b;
            end
        end
        exp_flag      = (a == b);
        exp_pc_branch = pc + (sx << 2);
        exp_mem_addr  = a + sx;
    endtask

    task automatic check_outputs();
        check_value("result", result, exp_result);
        check_value("flag", W'(flag), W'(exp_flag));
        check_value("pc_branch", pc_branch, exp_pc_branch);
        check_value("mem_addr", mem_addr, exp_mem_addr);
        check_value("hi", hi, hi_m);
        check_value("lo", lo, lo_m);
    endtask

    // counts edges until ack reaches level, sampled at the falling edge
    task automatic wait_for_ack(input logic level, input string what, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end while (ack !== level && cycles < WAIT_LIMIT);
        if (ack !== level) begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("timeout while waiting for %s at %0t", what, $time);
        end
    endtask

    task automatic run_transaction(input exec_op_t o, input logic [W-1:0] a,
                                   input logic [W-1:0] b, input logic [`EXEC_IMM_W-1:0] imm,
                                   input logic [W-1:0] pc);
        int lat;
        int exp_lat;
        int hold;
        if (timed_out) return;
        model_expect(o, a, b, imm, pc);
        exp_lat = (o == OP_MULTU || o == OP_DIVU) ? `EXEC_MULDIV_CYCLES + 2 : 2;
        @(posedge clk);
        req    <= 1'b1;
        op     <= o;
        rs     <= a;
        rt     <= b;
        immed  <= imm;
        pcadd4 <= pc;
        wait_for_ack(1'b1, "ack to rise after req", lat);
        if (timed_out) return;
        check_value("ack_rise_latency", lat, exp_lat);
        check_outputs();
        hold = $urandom_range(3);
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ack", W'(ack), W'(1'b1));
            check_outputs();
        end
        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(1'b0, "ack to fall after req dropped", lat);
        if (timed_out) return;
        check_value("ack_fall_latency", lat, 1);
        repeat ($urandom_range(2)) @(posedge clk);
    endtask

    task automatic random_transaction();
        logic [3:0]             sel;
        exec_op_t               o;
        logic [W-1:0]           a;
        logic [W-1:0]           b;
        logic [`EXEC_IMM_W-1:0] imm;
        sel = 4'($urandom_range(12));
        o   = exec_op_t'(sel);
        a   = pick_operand();
        b   = pick_operand();
        if ($urandom_range(7) == 0) b = a;
        if (o == OP_DIVU && $urandom_range(3) == 0) b = '0;
        imm = `EXEC_IMM_W'($urandom);
        run_transaction(o, a, b, imm, $urandom & 32'hffff_fffc);
    endtask

    task automatic reset_during_divide();
        if (timed_out) return;
        // known nonzero hi/lo for the reset to clear
        run_transaction(OP_MULTU, '1, '1, 16'h0000, 32'h0000_0400);
        if (timed_out) return;
        @(posedge clk);
        req    <= 1'b1;
        op     <= OP_DIVU;
        rs     <= 32'hdead_beef;
        rt     <= 32'h0000_0007;
        // still in the middle of the iterations here
        repeat (10) @(posedge clk);
        rst_n <= 1'b0;
        req   <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("hi", hi, '0);
        check_value("lo", lo, '0);
        hi_m = '0;
        lo_m = '0;
        @(posedge clk);
        rst_n <= 1'b1;
        // the aborted divide never comes back with an ack
        repeat (`EXEC_MULDIV_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ack", W'(ack), W'(1'b0));
        end
    endtask

    initial begin
        int seed_ret;
        clk      = 1'b0;
        rst_n    = 1'b0;
        req      = 1'b0;
        op       = OP_ADD;
        rs       = '0;
        rt       = '0;
        immed    = '0;
        pcadd4   = '0;
        hi_m     = '0;
        lo_m     = '0;
        seed_ret = $urandom(21582);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        run_transaction(OP_MULTU, '1, '1, 16'h0004, 32'h0000_1000);
        run_transaction(OP_MFHI, 32'h0000_0005, 32'h0000_0005, 16'hfffc, 32'h0000_2000);
        run_transaction(OP_MFLO, 32'h8000_0000, 32'h0, 16'h7fff, 32'h0000_3000);
        run_transaction(OP_DIVU, 32'h1234_5678, '0, 16'h8000, 32'h0040_0000);
        run_transaction(OP_MFHI, '0, '1, 16'h0001, 32'h0040_0004);
        run_transaction(OP_MFLO, '1, '0, 16'h0002, 32'h0040_0008);
        run_transaction(OP_DIVU, 32'h8000_0000, 32'h0000_0003, 16'h0010, 32'h0000_0100);

        for (int i = 0; i < N_RANDOM && !timed_out; i++) begin
            random_transaction();
        end

        reset_during_divide();
        run_transaction(OP_MFHI, 32'h0000_0011, 32'h0000_0022, 16'h0003, 32'h0000_0200);
        run_transaction(OP_DIVU, 32'h0000_0064, 32'h0000_0007, 16'hff00, 32'h0000_0300);
        run_transaction(OP_MFLO, 32'h0000_0001, 32'h0000_0001, 16'h0000, 32'h0000_0304);

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+source
source/exec_pkg.sv
source/exec_op_if.sv
source/exec_control_fsm.sv
source/muldiv_cycle_counter.sv
source/muldiv_unit.sv
source/alu_datapath.sv
source/exec_unit_top.sv
verif/exec_unit_sva.sv
verif/exec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module exec_unit_tb \
    --Mdir obj_dir -o exec_unit_sim

# a failing assertion ends the run early, the search below still decides
output=$(./obj_dir/exec_unit_sim) || true
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
